// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  // hi sits in the upper half, same order as {HI, LO}
  typedef struct packed {
    word_t hi;
    word_t lo;
  } hilo_t;

  // multiply/divide class of the ISA
  typedef enum logic [2:0] {
    MDU_MULT  = 3'd0,
    MDU_MULTU = 3'd1,
    MDU_DIV   = 3'd2,
    MDU_DIVU  = 3'd3,
    MDU_MTHI  = 3'd4,
    MDU_MTLO  = 3'd5
  } mdu_op_e;

endpackage

// ==== mdu_pkg.sv ====
package mdu_pkg;

  // one request, opr1 = rs and opr2 = rt
  // for MTHI/MTLO only opr1 counts
  typedef struct packed {
    mips_isa_pkg::mdu_op_e op;
    mips_isa_pkg::word_t   opr1;
    mips_isa_pkg::word_t   opr2;
  } mdu_req_t;

  typedef enum logic [1:0] {
    MDU_IDLE   = 2'd0,
    MDU_RUN    = 2'd1,
    MDU_FINISH = 2'd2
  } mdu_state_e;

  localparam int MDU_ITERS = 32;  // one bit per iteration

  typedef logic [5:0] cnt_t;

endpackage

// ==== hilo_regs.sv ====
module hilo_regs (
  input  bit                  clk,
  input  bit                  arst_n_i,
  input  bit                  hi_we_i,
  input  bit                  lo_we_i,
  input  mips_isa_pkg::hilo_t wdata_i,
  output mips_isa_pkg::hilo_t hilo_o
);
  import mips_isa_pkg::*;

  word_t hi_q;
  word_t lo_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hi_q <= '0;
    end else if (hi_we_i) begin
      hi_q <= wdata_i.hi;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lo_q <= '0;
    end else if (lo_we_i) begin
      lo_q <= wdata_i.lo;
    end
  end

  // read side, stands in for mfhi/mflo
  assign hilo_o = '{hi: hi_q, lo: lo_q};

endmodule

// ==== mdu_cycle_counter.sv ====
module mdu_cycle_counter (
  input  bit clk,
  input  bit arst_n_i,
  input  bit start_i,
  input  bit step_i,
  output bit last_o
);
  import mdu_pkg::*;

  cnt_t cnt_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= cnt_t'(MDU_ITERS - 1);
    end else if (step_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;  // holds at zero
    end
  end

  // only looked at while running
  assign last_o = (cnt_q == '0);

endmodule

// ==== mdu_multiplier.sv ====
module mdu_multiplier (
  input  bit                  clk,
  input  bit                  arst_n_i,
  input  bit                  start_i,
  input  bit                  step_i,
  input  bit                  is_signed_i,
  input  mips_isa_pkg::word_t opr1_i,
  input  mips_isa_pkg::word_t opr2_i,
  output mips_isa_pkg::hilo_t res_o
);
  import mips_isa_pkg::*;

  logic                neg_q;
  logic [2*WORD_W-1:0] mcand_q;
  logic [2*WORD_W-1:0] acc_q;
  word_t               mplier_q;
  word_t               abs1;
  word_t               abs2;
  logic [2*WORD_W-1:0] prod;

  assign abs1 = (is_signed_i && opr1_i[WORD_W-1]) ? -opr1_i : opr1_i;
  assign abs2 = (is_signed_i && opr2_i[WORD_W-1]) ? -opr2_i : opr2_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      neg_q <= 1'b0;
    end else if (start_i) begin
      neg_q <= is_signed_i && (opr1_i[WORD_W-1] ^ opr2_i[WORD_W-1]);
    end
  end

  // shift-add on magnitudes, multiplier lsb first
  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q  <= {{WORD_W{1'b0}}, abs1};
      mplier_q <= abs2;
      acc_q    <= '0;
    end else if (step_i) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign prod = neg_q ? -acc_q : acc_q;
  assign res_o = '{hi: prod[2*WORD_W-1:WORD_W], lo: prod[WORD_W-1:0]};

endmodule

// ==== mdu_divider.sv ====
module mdu_divider (
  input  bit                  clk,
  input  bit                  arst_n_i,
  input  bit                  start_i,
  input  bit                  step_i,
  input  bit                  is_signed_i,
  input  mips_isa_pkg::word_t opr1_i,
  input  mips_isa_pkg::word_t opr2_i,
  output mips_isa_pkg::hilo_t res_o
);
  import mips_isa_pkg::*;

  logic              quo_neg_q;
  logic              rem_neg_q;
  word_t             quo_q;  // dividend shifts out as quotient shifts in
  word_t             rem_q;
  word_t             dsor_q;
  word_t             abs1;
  word_t             abs2;
  logic [WORD_W:0]   rem_sh;
  logic [WORD_W+1:0] diff;
  word_t             quo_out;
  word_t             rem_out;

  assign abs1 = (is_signed_i && opr1_i[WORD_W-1]) ? -opr1_i : opr1_i;
  assign abs2 = (is_signed_i && opr2_i[WORD_W-1]) ? -opr2_i : opr2_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      quo_neg_q <= 1'b0;
      rem_neg_q <= 1'b0;
    end else if (start_i) begin
      quo_neg_q <= is_signed_i && (opr1_i[WORD_W-1] ^ opr2_i[WORD_W-1]);
      rem_neg_q <= is_signed_i && opr1_i[WORD_W-1];  // follows dividend
    end
  end

  assign rem_sh = {rem_q, quo_q[WORD_W-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dsor_q};

  // restoring step, keep the difference only when it is not negative
  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_q  <= abs1;
      rem_q  <= '0;
      dsor_q <= abs2;
    end else if (step_i) begin
      if (!diff[WORD_W+1]) begin
        rem_q <= diff[WORD_W-1:0];
        quo_q <= {quo_q[WORD_W-2:0], 1'b1};
      end else begin
        rem_q <= rem_sh[WORD_W-1:0];
        quo_q <= {quo_q[WORD_W-2:0], 1'b0};
      end
    end
  end

  assign quo_out = quo_neg_q ? -quo_q : quo_q;
  assign rem_out = rem_neg_q ? -rem_q : rem_q;
  assign res_o   = '{hi: rem_out, lo: quo_out};

endmodule

// ==== mdu_ctrl.sv ====
module mdu_ctrl (
  input  bit                  clk,
  input  bit                  arst_n_i,
  input  bit                  req_valid_i,
  input  mdu_pkg::mdu_req_t   req_i,
  input  bit                  flush_i,
  input  bit                  last_i,
  input  mips_isa_pkg::hilo_t mul_res_i,
  input  mips_isa_pkg::hilo_t div_res_i,
  output bit                  cnt_start_o,
  output bit                  mul_start_o,
  output bit                  div_start_o,
  output bit                  step_o,
  output bit                  is_signed_o,
  output mips_isa_pkg::word_t opr1_o,
  output mips_isa_pkg::word_t opr2_o,
  output bit                  hi_we_o,
  output bit                  lo_we_o,
  output mips_isa_pkg::hilo_t hilo_wdata_o,
  output bit                  busy_o,
  output bit                  done_o
);
  import mips_isa_pkg::*;
  import mdu_pkg::*;

  mdu_state_e state_q;
  mdu_state_e state_d;
  mdu_op_e    op_q;
  logic       div_zero_q;
  logic       done_q;
  logic       accept;
  logic       is_mul;
  logic       is_div;
  logic       is_mt;
  logic       commit;

  assign accept = req_valid_i && (state_q == MDU_IDLE) && !flush_i;
  assign is_mul = req_i.op inside {MDU_MULT, MDU_MULTU};
  assign is_div = req_i.op inside {MDU_DIV, MDU_DIVU};
  assign is_mt  = req_i.op inside {MDU_MTHI, MDU_MTLO};

  assign cnt_start_o = accept && (is_mul || is_div);
  assign mul_start_o = accept && is_mul;
  assign div_start_o = accept && is_div;
  assign step_o      = (state_q == MDU_RUN);
  assign is_signed_o = req_i.op inside {MDU_MULT, MDU_DIV};
  assign opr1_o      = req_i.opr1;
  assign opr2_o      = req_i.opr2;

  // a flush in the finish cycle still cancels the write
  assign commit = (state_q == MDU_FINISH) && !flush_i && !div_zero_q;

  always_comb begin
    hi_we_o      = commit;
    lo_we_o      = commit;
    hilo_wdata_o = (op_q inside {MDU_MULT, MDU_MULTU}) ? mul_res_i : div_res_i;
    if (accept && is_mt) begin  // direct moves, only the named half
      hi_we_o      = (req_i.op == MDU_MTHI);
      lo_we_o      = (req_i.op == MDU_MTLO);
      hilo_wdata_o = '{hi: req_i.opr1, lo: req_i.opr1};
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      MDU_IDLE: begin
        if (accept && !is_mt) state_d = MDU_RUN;
      end
      MDU_RUN: begin
        if (flush_i) state_d = MDU_IDLE;
        else if (last_i) state_d = MDU_FINISH;  // 32nd step happens on this edge
      end
      MDU_FINISH: state_d = MDU_IDLE;
      default:    state_d = MDU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= MDU_IDLE;
      op_q       <= MDU_MULT;
      div_zero_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept && !is_mt) begin
        op_q       <= req_i.op;
        div_zero_q <= is_div && (req_i.opr2 == '0);
      end
      done_q <= (accept && is_mt) || ((state_q == MDU_FINISH) && !flush_i);
    end
  end

  assign busy_o = (state_q != MDU_IDLE);
  assign done_o = done_q;

endmodule

// ==== mdu_top.sv ====
module mdu_top (
  input  bit                  clk,
  input  bit                  arst_n_i,
  input  bit                  req_valid_i,
  input  mdu_pkg::mdu_req_t   req_i,
  input  bit                  flush_i,
  output mips_isa_pkg::hilo_t hilo_o,
  output bit                  busy_o,
  output bit                  done_o
);
  import mips_isa_pkg::*;

  logic  cnt_start;
  logic  last;
  logic  mul_start;
  logic  div_start;
  logic  step;
  logic  is_signed;
  word_t opr1;
  word_t opr2;
  hilo_t mul_res;
  hilo_t div_res;
  logic  hi_we;
  logic  lo_we;
  hilo_t hilo_wdata;

  mdu_ctrl u_ctrl (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .flush_i      (flush_i),
    .last_i       (last),
    .mul_res_i    (mul_res),
    .div_res_i    (div_res),
    .cnt_start_o  (cnt_start),
    .mul_start_o  (mul_start),
    .div_start_o  (div_start),
    .step_o       (step),
    .is_signed_o  (is_signed),
    .opr1_o       (opr1),
    .opr2_o       (opr2),
    .hi_we_o      (hi_we),
    .lo_we_o      (lo_we),
    .hilo_wdata_o (hilo_wdata),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  mdu_cycle_counter u_cnt (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (cnt_start),
    .step_i   (step),
    .last_o   (last)
  );

  // both step together, only one of them was started
  mdu_multiplier u_mul (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .start_i     (mul_start),
    .step_i      (step),
    .is_signed_i (is_signed),
    .opr1_i      (opr1),
    .opr2_i      (opr2),
    .res_o       (mul_res)
  );

  mdu_divider u_div (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .start_i     (div_start),
    .step_i      (step),
    .is_signed_i (is_signed),
    .opr1_i      (opr1),
    .opr2_i      (opr2),
    .res_o       (div_res)
  );

  hilo_regs u_hilo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .hi_we_i  (hi_we),
    .lo_we_i  (lo_we),
    .wdata_i  (hilo_wdata),
    .hilo_o   (hilo_o)
  );

endmodule

// ==== mdu_sva.sv ====
module mdu_sva (
  input bit clk,
  input bit arst_n_i,
  input bit busy_i,
  input bit done_i
);
  import mdu_pkg::*;

  logic [6:0] busy_run_q;  // busy cycles so far

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_run_q <= '0;
    end else if (busy_i) begin
      busy_run_q <= busy_run_q + 7'd1;
    end else begin
      busy_run_q <= '0;
    end
  end

  done_busy_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(done_i && busy_i))
    else $error("done_o and busy_o high in the same cycle");

  // 32 run cycles plus finish
  busy_bounded: assert property (@(posedge clk) disable iff (!arst_n_i)
    busy_i |-> (busy_run_q < 7'(MDU_ITERS + 1)))
    else $error("busy_o held longer than one operation");

  done_single: assert property (@(posedge clk) disable iff (!arst_n_i)
    done_i |=> !done_i)
    else $error("done_o high for more than one cycle");

endmodule

bind mdu_top mdu_sva u_sva (
  .clk      (clk),
  .arst_n_i (arst_n_i),
  .busy_i   (busy_o),
  .done_i   (done_o)
);

// ==== tb_mdu.sv ====
module tb_mdu;
  import mips_isa_pkg::*;
  import mdu_pkg::*;

  localparam int N_RAND = 8;
  // mt 2, mul 48, div 48, div by zero 4, flush 6
  localparam int N_OPS = 108;
  localparam word_t CORNERS [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

  bit       clk;
  bit       arst_n_i;
  bit       req_valid_i;
  mdu_req_t req_i;
  bit       flush_i;
  hilo_t    hilo_o;
  bit       busy_o;
  bit       done_o;

  hilo_t model;     // expected HI/LO after everything issued so far
  hilo_t exp_q[$];  // one entry per expected done_o
  int    errors;
  int    n_checks;

  mdu_top DUT (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .flush_i     (flush_i),
    .hilo_o      (hilo_o),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  always #5 clk = ~clk;

  function automatic mdu_req_t make_req(input mdu_op_e op, input word_t a, input word_t b);
    mdu_req_t r;
    r.op   = op;
    r.opr1 = a;
    r.opr2 = b;
    return r;
  endfunction

  // HI/LO after one request, worked out at 64 bits
  function automatic hilo_t ref_hilo(input mdu_req_t req, input hilo_t prev);
    hilo_t              r;
    logic signed [63:0] a_s;
    logic signed [63:0] b_s;
    logic signed [63:0] res_s;
    logic signed [63:0] rem_s;
    logic [63:0]        a_u;
    logic [63:0]        b_u;
    logic [63:0]        res_u;
    r   = prev;
    a_s = $signed(req.opr1);
    b_s = $signed(req.opr2);
    a_u = {32'h0, req.opr1};
    b_u = {32'h0, req.opr2};
    case (req.op)
      MDU_MULT: begin
        res_s = a_s * b_s;
        r     = '{hi: res_s[63:32], lo: res_s[31:0]};
      end
      MDU_MULTU: begin
        res_u = a_u * b_u;
        r     = '{hi: res_u[63:32], lo: res_u[31:0]};
      end
      MDU_DIV: begin
        if (req.opr2 != 32'h0) begin
          res_s = a_s / b_s;
          rem_s = a_s % b_s;  // sign of the dividend
          r     = '{hi: rem_s[31:0], lo: res_s[31:0]};
        end
      end
      MDU_DIVU: begin
        if (req.opr2 != 32'h0) begin
          r = '{hi: 32'(a_u % b_u), lo: 32'(a_u / b_u)};
        end
      end
      MDU_MTHI: r.hi = req.opr1;
      MDU_MTLO: r.lo = req.opr1;
      default:  r = prev;
    endcase
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) $display("test %0d %s: ok", num, name);
    else $display("test %0d %s: FAILED, %0d errors", num, name, errors - errs_before);
  endtask

  // issue one request and follow busy_o until done_o
  task automatic run_op(input mdu_req_t req);
    int busy_cycles;
    int waited;
    bit seen;
    model = ref_hilo(req, model);
    exp_q.push_back(model);
    @(posedge clk);
    #1;
    req_valid_i = 1'b1;
    req_i       = req;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
    busy_cycles = 0;
    waited      = 0;
    seen        = 1'b0;
    while (!seen && waited < MDU_ITERS + 8) begin
      @(negedge clk);
      if (busy_o) busy_cycles++;
      seen = done_o;
      waited++;
    end
    if (!seen) begin
      $display("done_o never pulsed for op %s", req.op.name());
      errors++;
    end else if (req.op inside {MDU_MTHI, MDU_MTLO}) begin
      check("done_o latency", waited, 1);  // right after the accept edge
    end else begin
      check("done_o latency", waited, MDU_ITERS + 2);  // just after the 33 busy cycles
    end
    if (req.op inside {MDU_MTHI, MDU_MTLO}) check("busy_o cycles", busy_cycles, 0);
    else check("busy_o cycles", busy_cycles, MDU_ITERS + 1);
    @(posedge clk);  // let the compare process finish
  endtask

  // start an operation and cancel it after a number of cycles
  task automatic flush_op(input mdu_req_t req, input int after);
    @(posedge clk);
    #1;
    req_valid_i = 1'b1;
    req_i       = req;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
    repeat (after) @(posedge clk);
    #1 flush_i = 1'b1;
    @(posedge clk);
    #1 flush_i = 1'b0;
    @(negedge clk);
    check("busy_o", busy_o, 0);
    repeat (MDU_ITERS + 4) @(negedge clk);  // a stray done_o would land in here
    check("hilo_o", hilo_o, model);
  endtask

  initial begin : compare
    hilo_t exp;
    forever begin
      @(negedge clk);
      if (done_o) begin
        if (exp_q.size() == 0) begin
          $display("done_o pulsed with no operation outstanding");
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check("hilo_o", hilo_o, exp);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (N_OPS * 40 + 100) @(posedge clk);
    $display("watchdog expired before all tests completed");
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    int    errs_before;
    word_t a;
    word_t b;
    void'($urandom(32'h3d6a_4381));
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    flush_i     = 1'b0;
    model       = '0;
    errors      = 0;
    n_checks    = 0;
    repeat (16) @(posedge clk);
    #1 arst_n_i = 1'b1;

    errs_before = errors;
    @(negedge clk);
    check("hilo_o", hilo_o, 64'h0);
    check("busy_o", busy_o, 0);
    check("done_o", done_o, 0);
    report_test(1, "reset state", errs_before);

    errs_before = errors;
    run_op(make_req(MDU_MTHI, $urandom, $urandom));
    run_op(make_req(MDU_MTLO, $urandom, $urandom));
    report_test(2, "mthi/mtlo", errs_before);

    errs_before = errors;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_op(make_req(MDU_MULT, CORNERS[i], CORNERS[j]));
        run_op(make_req(MDU_MULTU, CORNERS[i], CORNERS[j]));
      end
    end
    for (int i = 0; i < N_RAND; i++) begin
      run_op(make_req(MDU_MULT, $urandom, $urandom));
      run_op(make_req(MDU_MULTU, $urandom, $urandom));
    end
    report_test(3, "mult/multu", errs_before);

    errs_before = errors;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_op(make_req(MDU_DIV, CORNERS[i], CORNERS[j]));
        run_op(make_req(MDU_DIVU, CORNERS[i], CORNERS[j]));
      end
    end
    for (int i = 0; i < N_RAND; i++) begin
      a = $urandom;
      b = $urandom >> (i * 3);  // small divisors too
      run_op(make_req(MDU_DIV, a, b));
      run_op(make_req(MDU_DIVU, a, b));
    end
    report_test(4, "div/divu", errs_before);

    errs_before = errors;
    run_op(make_req(MDU_MTHI, $urandom, 32'h0));
    run_op(make_req(MDU_MTLO, $urandom, 32'h0));
    run_op(make_req(MDU_DIV, $urandom, 32'h0));
    run_op(make_req(MDU_DIVU, $urandom, 32'h0));
    report_test(5, "divide by zero", errs_before);

    errs_before = errors;
    flush_op(make_req(MDU_MULT, $urandom, $urandom), 10);
    run_op(make_req(MDU_MULT, $urandom, $urandom));
    flush_op(make_req(MDU_DIV, $urandom, $urandom | 32'h1), 10);
    run_op(make_req(MDU_DIV, $urandom, $urandom));
    flush_op(make_req(MDU_DIVU, $urandom, $urandom | 32'h1), MDU_ITERS);  // finish cycle
    run_op(make_req(MDU_DIVU, $urandom, $urandom));
    report_test(6, "flush", errs_before);

    $display("checks %0d, errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
mips_isa_pkg.sv
mdu_pkg.sv
hilo_regs.sv
mdu_cycle_counter.sv
mdu_multiplier.sv
mdu_divider.sv
mdu_ctrl.sv
mdu_top.sv
mdu_sva.sv
tb_mdu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdu -f flist.f -o sim_mdu

# a failing assertion stops the run early, the search below then fails
out=$(./obj_dir/sim_mdu) || true
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
